//--- files.f
+incdir+src
+incdir+testbench
src/ntt_arith_pkg.sv
src/ntt_flow_pkg.sv
src/bfly_decode.sv
src/bfly_execute.sv
src/bfly_result.sv
src/bfly_top.sv
testbench/tb_bfly.sv

//--- Makefile
# Verilator build and run for the NTT butterfly testbench

VERILATOR ?= verilator
TOP       ?= tb_bfly
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  := Simulation finished: PASS

SOURCES := $(wildcard src/*.sv src/*.svh testbench/*.sv testbench/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_bfly_ref.svh
`ifndef TB_BFLY_REF_SVH
`define TB_BFLY_REF_SVH

localparam longint ref_q    = `NTT_Q;
localparam longint ref_half = (ref_q - 1) / 2;
// 2 * ref_inv2 = q + 1
localparam longint ref_inv2 = (ref_q + 1) / 2;

function automatic longint mod_q(longint x);
  longint r;
  r = x % ref_q;
  if (r < 0) begin
    r = r + ref_q;
  end
  return r;
endfunction

// representative in [-half, half]
function automatic longint center_q(longint x);
  longint r;
  r = mod_q(x);
  if (r > ref_half) begin
    r = r - ref_q;
  end
  return r;
endfunction

// expected pair for one operation on canonical inputs
function automatic void ref_bfly(input bfly_op_t op, input int a, input int b, input int w,
                                 output int exp_a, output int exp_b);
  longint ca;
  longint cb;
  longint cw;
  longint t;
  longint s;
  longint d;
  ca = center_q(longint'(a));
  cb = center_q(longint'(b));
  cw = center_q(longint'(w));
  t  = center_q(cb * cw);
  case (op)
    op_fwd: begin
      s = ca + t;
      d = ca - t;
    end
    op_inv: begin
      s = (ca + t) * ref_inv2;
      d = (ca - t) * ref_inv2;
    end
    // reserved code behaves as pointwise multiply
    default: begin
      s = t;
      d = -t;
    end
  endcase
  exp_a = int'(center_q(s));
  exp_b = int'(center_q(d));
endfunction

task automatic check_val(input string name, input int expected, input int actual);
  checks++;
  if (expected != actual) begin
    errors++;
    $display("FAIL %s: expected 0x%08h, got 0x%08h at %0d ns", name, expected, actual, $time);
  end
endtask

`endif

//--- testbench/tb_bfly.sv
`timescale 1ns/10ps
`default_nettype none

`include "ntt_defines.svh"

module tb_bfly;

  import ntt_arith_pkg::*;

  localparam int clk_period = 40;
  localparam int n_bp    = `NTT_BUF_DEPTH;
  localparam int n_fwd   = 200;
  localparam int n_inv   = 200;
  localparam int n_pmul  = 100;
  localparam int n_edge  = 3 * 125;
  localparam int n_mixed = 300;
  localparam int n_total = n_bp + n_fwd + n_inv + n_pmul + n_edge + n_mixed;
  localparam longint watchdog_ns =
    longint'(n_total * (`NTT_PIPE_DEPTH + 8) * clk_period + 4 * clk_period);

  logic     clk;
  logic     rst;
  logic     in_valid;
  bfly_op_t in_op;
  coef_t    in_a;
  coef_t    in_b;
  coef_t    in_w;
  logic     in_credit;
  logic     out_valid;
  coef_t    out_a;
  coef_t    out_b;
  logic     out_credit;

  int errors = 0;
  int checks = 0;
  int sent = 0;
  int results = 0;
  int in_credits = 0;
  int grants_seen = 0;
  int grants_issued = 0;
  int grant_reqs = 0;
  int grant_reqs_done = 0;
  // 0 on request, 1 always, 2 randomly gapped
  int grant_mode = 0;
  int exp_a_q[$];
  int exp_b_q[$];

  `include "tb_bfly_ref.svh"

  bfly_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_w       (in_w),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_a      (out_a),
    .out_b      (out_b),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns with %0d of %0d results", watchdog_ns, results, sent);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // compare and count at the rising edge
  initial begin
    forever begin
      @(posedge clk);
      if (!rst) begin
        if (out_valid) begin
          if (results >= grants_seen) begin
            errors++;
            $display("out_valid at %0d ns beyond the granted credits", $time);
          end
          if (exp_a_q.size() == 0) begin
            errors++;
            $display("out_valid at %0d ns with no result expected", $time);
          end else begin
            check_val("out_a", exp_a_q.pop_front(), int'(out_a));
            check_val("out_b", exp_b_q.pop_front(), int'(out_b));
          end
          results++;
        end
        if (in_credit) begin
          in_credits++;
        end
        if (out_credit) begin
          grants_seen++;
        end
      end
    end
  end

  // downstream grants with at most one buffer's worth outstanding
  initial begin
    out_credit = 1'b0;
    forever begin
      @(negedge clk);
      out_credit = 1'b0;
      if (!rst && grants_issued - results < `NTT_BUF_DEPTH) begin
        case (grant_mode)
          0:       out_credit = (grant_reqs > grant_reqs_done);
          1:       out_credit = 1'b1;
          default: out_credit = ($urandom % 3 == 0);
        endcase
      end
      if (out_credit) begin
        grants_issued++;
        if (grant_mode == 0) begin
          grant_reqs_done++;
        end
      end
    end
  end

  function automatic int rand_coef();
    return int'($urandom % `NTT_Q);
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // starts on a falling edge and waits for input credit first
  task automatic send_op(input bfly_op_t op, input int a, input int b, input int w);
    int exp_a;
    int exp_b;
    int waited;
    waited = 0;
    while (`NTT_BUF_DEPTH - sent + in_credits == 0 && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (`NTT_BUF_DEPTH - sent + in_credits == 0) begin
      errors++;
      $display("no input credit came back within %0d cycles", waited);
    end else begin
      ref_bfly(op, a, b, w, exp_a, exp_b);
      exp_a_q.push_back(exp_a);
      exp_b_q.push_back(exp_b);
      in_valid = 1'b1;
      in_op    = op;
      in_a     = coef_t'(a);
      in_b     = coef_t'(b);
      in_w     = coef_t'(w);
      sent++;
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_results(input int target, input int max_cycles);
    int n;
    n = 0;
    while (results < target && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (results < target) begin
      errors++;
      $display("timed out waiting for result %0d, only %0d arrived", target, results);
    end
  endtask

  initial begin
    int i;
    int j;
    int k;
    int m;
    int edges[5];
    bfly_op_t modes[3];
    void'($urandom(32'h77a5461c));
    rst      = 1'b1;
    in_valid = 1'b0;
    in_op    = op_fwd;
    in_a     = '0;
    in_b     = '0;
    in_w     = '0;
    edges    = '{0, 1, int'(ref_half), int'(ref_half) + 1, int'(ref_q) - 1};
    modes    = '{op_fwd, op_inv, op_pmul};
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // fill the buffer with no downstream credit and release it one grant at a time
    for (i = 0; i < n_bp; i++) begin
      send_op(op_fwd, rand_coef(), rand_coef(), rand_coef());
    end
    wait_cycles(4 * `NTT_PIPE_DEPTH);
    check_val("results before any grant", 0, results);
    check_val("in_credit before any grant", 0, in_credits);
    for (i = 1; i <= n_bp; i++) begin
      grant_reqs++;
      wait_results(i, 20);
      wait_cycles(4);
      check_val("results per grant", i, results);
      check_val("in_credit per result", i, in_credits);
    end

    grant_mode = 1;
    for (i = 0; i < n_fwd; i++) begin
      send_op(op_fwd, rand_coef(), rand_coef(), rand_coef());
    end
    for (i = 0; i < n_inv; i++) begin
      send_op(op_inv, rand_coef(), rand_coef(), rand_coef());
    end
    for (i = 0; i < n_pmul; i++) begin
      send_op(op_pmul, rand_coef(), rand_coef(), rand_coef());
    end
    for (m = 0; m < 3; m++) begin
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          for (k = 0; k < 5; k++) begin
            send_op(modes[m], edges[i], edges[j], edges[k]);
          end
        end
      end
    end

    // mixed modes including the reserved code with gapped grants
    grant_mode = 2;
    for (i = 0; i < n_mixed; i++) begin
      send_op(bfly_op_t'(2'($urandom % 4)), rand_coef(), rand_coef(), rand_coef());
    end
    wait_results(sent, 50 + 16 * (sent - results));
    wait_cycles(4);
    check_val("in_credit pulses", sent, in_credits);
    check_val("results pending", 0, exp_a_q.size());

    $display("tb_bfly: %0d operations, %0d checks, %0d errors", sent, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/bfly_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "ntt_defines.svh"

module bfly_top (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          in_valid,
  input  wire ntt_arith_pkg::bfly_op_t in_op,
  input  wire ntt_arith_pkg::coef_t    in_a,
  input  wire ntt_arith_pkg::coef_t    in_b,
  input  wire ntt_arith_pkg::coef_t    in_w,
  output logic                         in_credit,
  output logic                         out_valid,
  output ntt_arith_pkg::coef_t         out_a,
  output ntt_arith_pkg::coef_t         out_b,
  input  wire                          out_credit
);

  import ntt_arith_pkg::*;

  logic  dec_valid;
  logic  dec_inverse;
  coef_t dec_a;
  coef_t dec_b;
  coef_t dec_w;

  logic                        ex_valid;
  logic                        ex_inverse;
  logic signed [`NTT_COEF_W:0] ex_sum;
  logic signed [`NTT_COEF_W:0] ex_diff;

  bfly_decode i_decode (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_op       (in_op),
    .in_a        (in_a),
    .in_b        (in_b),
    .in_w        (in_w),
    .dec_valid   (dec_valid),
    .dec_inverse (dec_inverse),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_w       (dec_w)
  );

  bfly_execute i_execute (
    .clk         (clk),
    .rst         (rst),
    .dec_valid   (dec_valid),
    .dec_inverse (dec_inverse),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_w       (dec_w),
    .ex_valid    (ex_valid),
    .ex_inverse  (ex_inverse),
    .ex_sum      (ex_sum),
    .ex_diff     (ex_diff)
  );

  bfly_result i_result (
    .clk        (clk),
    .rst        (rst),
    .ex_valid   (ex_valid),
    .ex_inverse (ex_inverse),
    .ex_sum     (ex_sum),
    .ex_diff    (ex_diff),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_a      (out_a),
    .out_b      (out_b),
    .out_credit (out_credit)
  );

endmodule

`default_nettype wire

//--- src/bfly_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "ntt_defines.svh"

module bfly_result (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         ex_valid,
  input  wire                         ex_inverse,
  input  wire signed [`NTT_COEF_W:0]  ex_sum,
  input  wire signed [`NTT_COEF_W:0]  ex_diff,
  output logic                        in_credit,
  output logic                        out_valid,
  output ntt_arith_pkg::coef_t        out_a,
  output ntt_arith_pkg::coef_t        out_b,
  input  wire                         out_credit
);

  import ntt_arith_pkg::*;
  import ntt_flow_pkg::*;

  typedef logic signed [`NTT_COEF_W:0] sum_t;

  localparam sum_t q_s    = sum_t'(`NTT_Q);
  localparam sum_t half_s = sum_t'(half_q);

  // forward folds into the centered range, inverse halves mod q
  function automatic coef_t fold(sum_t x, logic inverse);
    sum_t x_add;
    sum_t x_sub;
    sum_t y;
    x_add = x + q_s;
    x_sub = x - q_s;
    if (!inverse) begin
      if (x > half_s) begin
        y = x_sub;
      end else if (x < -half_s) begin
        y = x_add;
      end else begin
        y = x;
      end
    end else if (!x[`NTT_COEF_W]) begin
      // odd values get an even neighbour first
      y = x[0] ? (x_sub >>> 1) : (x >>> 1);
    end else begin
      y = x[0] ? (x_add >>> 1) : (x >>> 1);
    end
    return coef_t'(y);
  endfunction

  logic     fold_valid;
  coef_t    fold_a;
  coef_t    fold_b;
  coef_t    buf_a [`NTT_BUF_DEPTH];
  coef_t    buf_b [`NTT_BUF_DEPTH];
  buf_ptr_t wr_ptr;
  buf_ptr_t rd_ptr;
  credit_t  dn_credit;
  logic     pop;

  assign pop       = (wr_ptr != rd_ptr) && (dn_credit != '0);
  assign out_valid = pop;
  assign out_a     = buf_a[rd_ptr[buf_idx_w-1:0]];
  assign out_b     = buf_b[rd_ptr[buf_idx_w-1:0]];

  always_ff @(posedge clk) begin
    if (rst) begin
      fold_valid <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      dn_credit  <= '0;
      in_credit  <= 1'b0;
    end else begin
      fold_valid <= ex_valid;
      if (fold_valid) begin
        wr_ptr <= wr_ptr + buf_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + buf_ptr_t'(1);
      end
      dn_credit <= dn_credit + credit_t'(out_credit) - credit_t'(pop);
      // slot freed, hand the credit back upstream
      in_credit <= pop;
    end
  end

  always_ff @(posedge clk) begin
    fold_a <= fold(ex_sum, ex_inverse);
    fold_b <= fold(ex_diff, ex_inverse);
    if (fold_valid) begin
      buf_a[wr_ptr[buf_idx_w-1:0]] <= fold_a;
      buf_b[wr_ptr[buf_idx_w-1:0]] <= fold_b;
    end
  end

endmodule

`default_nettype wire

//--- src/bfly_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "ntt_defines.svh"

module bfly_execute (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         dec_valid,
  input  wire                         dec_inverse,
  input  wire ntt_arith_pkg::coef_t   dec_a,
  input  wire ntt_arith_pkg::coef_t   dec_b,
  input  wire ntt_arith_pkg::coef_t   dec_w,
  output logic                        ex_valid,
  output logic                        ex_inverse,
  output logic signed [`NTT_COEF_W:0] ex_sum,
  output logic signed [`NTT_COEF_W:0] ex_diff
);

  import ntt_arith_pkg::*;

  localparam int pm_w = $bits(prod_t) + 20;

  typedef logic signed [pm_w-1:0] pm_t;
  typedef logic signed [`NTT_COEF_W:0] sum_t;

  localparam prod_t q_p     = prod_t'(`NTT_Q);
  localparam prod_t half_p  = prod_t'(half_q);
  localparam pm_t   m_p     = pm_t'(barrett_m);
  localparam pm_t   round_p = pm_t'(1) <<< (barrett_k - 1);

  logic [2:0] vld;
  logic [2:0] inv;

  // stage 1
  prod_t prod1;
  coef_t a1;
  // stage 2
  pm_t   pm2;
  prod_t prod2;
  coef_t a2;
  // stage 3
  coef_t red3;
  coef_t a3;

  pm_t   rounded;
  prod_t quot;
  prod_t rem;

  always_comb begin
    rounded = pm2 + round_p;
    quot    = prod_t'(rounded >>> barrett_k);
    rem     = prod2 - quot * q_p;
    // estimate may be one off, one correction brings it back
    if (rem > half_p) begin
      rem = rem - q_p;
    end else if (rem < -half_p) begin
      rem = rem + q_p;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld      <= '0;
      ex_valid <= 1'b0;
    end else begin
      vld      <= {vld[1:0], dec_valid};
      ex_valid <= vld[2];
    end
  end

  always_ff @(posedge clk) begin
    inv        <= {inv[1:0], dec_inverse};
    ex_inverse <= inv[2];

    prod1 <= prod_t'(dec_b) * prod_t'(dec_w);
    a1    <= dec_a;

    pm2   <= pm_t'(prod1) * m_p;
    prod2 <= prod1;
    a2    <= a1;

    red3 <= coef_t'(rem);
    a3   <= a2;

    ex_sum  <= sum_t'(a3) + sum_t'(red3);
    ex_diff <= sum_t'(a3) - sum_t'(red3);
  end

endmodule

`default_nettype wire

//--- src/bfly_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "ntt_defines.svh"

module bfly_decode (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      in_valid,
  input  wire ntt_arith_pkg::bfly_op_t in_op,
  input  wire ntt_arith_pkg::coef_t  in_a,
  input  wire ntt_arith_pkg::coef_t  in_b,
  input  wire ntt_arith_pkg::coef_t  in_w,
  output logic                     dec_valid,
  output logic                     dec_inverse,
  output ntt_arith_pkg::coef_t     dec_a,
  output ntt_arith_pkg::coef_t     dec_b,
  output ntt_arith_pkg::coef_t     dec_w
);

  import ntt_arith_pkg::*;

  typedef logic [`NTT_COEF_W-1:0] raw_t;

  localparam raw_t half_u = raw_t'(half_q);
  localparam raw_t q_u    = raw_t'(`NTT_Q);

  // canonical [0, q) to [-half_q, half_q]
  function automatic coef_t center(coef_t x);
    raw_t u;
    u = raw_t'(x);
    if (u > half_u) begin
      return coef_t'(u - q_u);
    end
    return x;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    dec_b       <= center(in_b);
    dec_w       <= center(in_w);
    dec_inverse <= (in_op == op_inv);
    case (in_op)
      op_fwd, op_inv: dec_a <= center(in_a);
      // sum and diff turn into bw and -bw
      default:        dec_a <= '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/ntt_flow_pkg.sv
`default_nettype none

`include "ntt_defines.svh"

package ntt_flow_pkg;

  localparam int buf_idx_w = $clog2(`NTT_BUF_DEPTH);
  localparam int credit_w  = $clog2(`NTT_BUF_DEPTH + 1);

  typedef logic [credit_w-1:0] credit_t;

  // extra msb tells full from empty
  typedef logic [buf_idx_w:0] buf_ptr_t;

endpackage

`default_nettype wire

//--- src/ntt_arith_pkg.sv
`default_nettype none

`include "ntt_defines.svh"

package ntt_arith_pkg;

  // coefficients travel in centered signed form
  typedef logic signed [`NTT_COEF_W-1:0] coef_t;

  typedef logic signed [2*`NTT_COEF_W-1:0] prod_t;

  // code 2'd3 is reserved, decoded as pointwise multiply
  typedef enum logic [1:0] {
    op_fwd  = 2'd0,
    op_inv  = 2'd1,
    op_pmul = 2'd2
  } bfly_op_t;

  // bound of the centered range
  localparam int half_q = (`NTT_Q - 1) / 2;

  // quotient estimate is round(p * barrett_m / 2^barrett_k)
  // off by at most one for any product of two centered values
  localparam int barrett_k = 36;
  localparam int barrett_m = 419427;

endpackage

`default_nettype wire

//--- src/ntt_defines.svh
`ifndef NTT_DEFINES_SVH
`define NTT_DEFINES_SVH

// prime modulus, q = 5 * 2^15 + 1
`define NTT_Q 163841

`define NTT_COEF_W 18

// result buffer slots, also the sender's starting credit
`define NTT_BUF_DEPTH 8

// accepting edge to buffer write
`define NTT_PIPE_DEPTH 6

`endif
